/* sources.f */
+incdir+include
source/sprite_pkg.sv
source/sprite_list_copy.sv
source/sprite_gfx_rom.sv
source/sprite_line_render.sv
source/sprite_engine_top.sv
testbench/tb_sprite_engine.sv

/* Makefile */
# sprite engine simulation with Verilator

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_sprite_engine
FILELIST = sources.f
LOG      = sim.log
PASS     = Done: no errors

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, fail unless it passes"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* testbench/tb_sprite_engine.sv */
`timescale 1ns/1ns
// ====================
// renders display line 100 only, against a model built from copies of list and rom
// the full rom load takes most of the run time
// ====================
`include "sprite_config.svh"

module tb_sprite_engine
    import sprite_pkg::*;
();

    localparam line_t LINE = 9'd100;

    logic       clk_sys;
    logic       reset;
    logic       vblank;
    line_t      h_count;
    line_t      v_count;
    logic       irq_ack;
    logic       list_wr_valid;
    list_addr_t list_wr_addr;
    byte_t      list_wr_data;
    logic       gfx_wr_valid;
    gfx_addr_t  gfx_wr_addr;
    byte_t      gfx_wr_data;
    byte_t      pix_x;
    logic       irq;
    logic       copy_busy;
    logic       line_done;
    logic       list_wr_ready;
    logic       gfx_wr_ready;
    pixel_t     pix_data;

    // reference copies
    byte_t       list_model [`SPRITE_COUNT * `SPRITE_BYTES];
    byte_t       gfx_model [1 << `GFX_ADDR_W];
    pixel_t      exp_line [`LINE_WIDTH];
    logic [31:0] lcg_state;
    tile_t       top_tile;
    string       test_name;
    int          err_count;
    int          test_errs;
    int          tests_run;
    int          tests_failed;
    int          waited;

    sprite_engine_top DUT (.*);

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    // ==================== interrupt and back-pressure rules
    a_irq_on_rise: assert property (@(posedge clk_sys) disable iff (reset)
        $rose(vblank) |=> irq) else begin
        $display("irq was not set after a vblank rising edge");
        err_count++;
    end
    a_irq_on_fall: assert property (@(posedge clk_sys) disable iff (reset)
        $fell(vblank) |=> !irq) else begin
        $display("irq was not cleared after a vblank falling edge");
        err_count++;
    end
    a_irq_on_ack: assert property (@(posedge clk_sys) disable iff (reset)
        (irq_ack && !$rose(vblank)) |=> !irq) else begin
        $display("irq was not cleared by irq_ack");
        err_count++;
    end
    a_list_held: assert property (@(posedge clk_sys) disable iff (reset)
        copy_busy |-> !list_wr_ready) else begin
        $display("list_wr_ready was high while the copy was busy");
        err_count++;
    end

    function automatic byte_t rand_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    task automatic tick();
        @(posedge clk_sys);
        #5;
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("FAILED %s %s: expected %0h actual %0h", test_name, what, expected, actual);
            err_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = err_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_count == test_errs) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, err_count - test_errs);
        end
    endtask

    // ==================== host writes, valid held until accepted
    task automatic write_list(input int addr, input byte_t data, output int wait_clks);
        list_wr_addr  = list_addr_t'(addr);
        list_wr_data  = data;
        list_wr_valid = 1'b1;
        wait_clks = 0;
        while (!list_wr_ready && wait_clks < 1000) begin
            tick();
            wait_clks++;
        end
        if (!list_wr_ready) begin
            $display("timeout: list write to %0d was never accepted", addr);
            err_count++;
        end
        tick();
        list_wr_valid = 1'b0;
        list_model[addr] = data;
    endtask

    task automatic write_gfx(input int addr, input byte_t data);
        int t;
        gfx_wr_addr  = gfx_addr_t'(addr);
        gfx_wr_data  = data;
        gfx_wr_valid = 1'b1;
        t = 0;
        while (!gfx_wr_ready && t < 5000) begin
            tick();
            t++;
        end
        if (!gfx_wr_ready) begin
            $display("timeout: graphics write to %0h was never accepted", addr);
            err_count++;
        end
        tick();
        gfx_wr_valid = 1'b0;
        gfx_model[addr] = data;
    endtask

    // list bytes from screen position, inverse of the list decode
    task automatic set_sprite(input int slot, input int y, input tile_t tile, input int x,
                              input colour_t colour, input logic fx, input logic fy);
        xpos_t raw;
        raw = xpos_t'(x + `X_BIAS);
        write_list(4 * slot, byte_t'(`Y_ORIGIN - y), waited);
        write_list(4 * slot + 1, tile[7:0], waited);
        write_list(4 * slot + 2, {colour, fy, fx, tile[8], raw[8]}, waited);
        write_list(4 * slot + 3, raw[7:0], waited);
    endtask

    // ==================== vblank copy
    task automatic wait_copy_done(output int n);
        n = 0;
        while (copy_busy && n < 1000) begin
            tick();
            n++;
        end
        if (copy_busy) begin
            $display("timeout: copy_busy never fell");
            err_count++;
        end
    endtask

    task automatic copy_list();
        int n;
        vblank = 1'b1;
        n = 0;
        while (!copy_busy && n < 10) begin
            tick();
            n++;
        end
        if (!copy_busy) begin
            $display("timeout: copy_busy never rose after vblank");
            err_count++;
        end
        check_value("irq at copy start", 1, irq);
        wait_copy_done(n);
        check_value("copy clocks", `SPRITE_COUNT * 7, n);
        vblank = 1'b0;
        tick();
        check_value("irq after vblank fall", 0, irq);
    endtask

    // ==================== line model and render
    task automatic build_expected(input line_t l);
        byte_t      b2;
        ypos_t      y;
        tile_t      tile;
        xpos_t      x;
        line_t      px;
        logic [3:0] fr;
        logic [3:0] fo;
        byte_t      d;
        pen_t       p;
        for (int i = 0; i < `LINE_WIDTH; i++) begin
            exp_line[i] = '0;
        end
        // slot order, so later slots land on top
        for (int s = 0; s < `SPRITE_COUNT; s++) begin
            b2   = list_model[4 * s + 2];
            y    = ypos_t'(`Y_ORIGIN) - list_model[4 * s];
            tile = {b2[1], list_model[4 * s + 1]};
            x    = {b2[0], list_model[4 * s + 3]} - xpos_t'(`X_BIAS);
            if (l >= line_t'(y) && l < line_t'(y) + 9'd16 && x < 9'd256) begin
                fr = b2[3] ? 4'd15 - 4'(l - line_t'(y)) : 4'(l - line_t'(y));
                for (int o = 0; o < `SPRITE_SIZE; o++) begin
                    fo = b2[2] ? 4'(15 - o) : 4'(o);
                    d  = gfx_model[{1'b0, fo[1], tile, fr, fo[3:2]}];
                    p  = fo[0] ? d[7:4] : d[3:0];
                    px = x + line_t'(o);
                    if (p != pen_t'(`TRANS_PEN) && px < 9'd256) begin
                        exp_line[px[7:0]] = {b2[7:4], p};
                    end
                end
            end
        end
    endtask

    task automatic render_line();
        int t;
        build_expected(LINE);
        v_count = LINE - 1'b1;
        h_count = 9'd256;
        tick();
        t = 0;
        while (!line_done && t < 5000) begin
            check_value("gfx_wr_ready while rendering", 0, gfx_wr_ready);
            tick();
            t++;
        end
        if (!line_done) begin
            $display("timeout: line_done never pulsed");
            err_count++;
        end
        h_count = '0;
        for (int i = 0; i < `LINE_WIDTH; i++) begin
            pix_x = byte_t'(i);
            tick();
            check_value($sformatf("pixel %0d", i), exp_line[i], pix_data);
        end
    endtask

    // ==================== test sequence
    initial begin
        lcg_state     = 32'd21;
        err_count     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        reset         = 1'b1;
        vblank        = 1'b0;
        h_count       = '0;
        v_count       = '0;
        irq_ack       = 1'b0;
        list_wr_valid = 1'b0;
        list_wr_addr  = '0;
        list_wr_data  = '0;
        gfx_wr_valid  = 1'b0;
        gfx_wr_addr   = '0;
        gfx_wr_data   = '0;
        pix_x         = '0;
        repeat (2) @(posedge clk_sys);
        #5;
        reset = 1'b0;

        start_test("reset");
        check_value("irq", 0, irq);
        check_value("copy_busy", 0, copy_busy);
        check_value("line_done", 0, line_done);
        waited = 0;
        while (!(list_wr_ready && gfx_wr_ready) && waited < 10) begin
            tick();
            waited++;
        end
        check_value("clocks until ready", 1, waited);
        end_test();

        // random rom, every sprite parked below the display
        for (int a = 0; a < (1 << `GFX_ADDR_W); a++) begin
            write_gfx(a, rand_byte());
        end
        for (int s = 0; s < `SPRITE_COUNT; s++) begin
            set_sprite(s, `Y_ORIGIN, tile_t'({rand_byte(), rand_byte()}), rand_byte(),
                       colour_t'(rand_byte()), 1'(rand_byte()), 1'(rand_byte()));
        end

        start_test("irq");
        vblank = 1'b1;
        tick();
        check_value("irq after vblank rise", 1, irq);
        irq_ack = 1'b1;
        tick();
        irq_ack = 1'b0;
        check_value("irq after ack", 0, irq);
        wait_copy_done(waited);
        vblank = 1'b0;
        tick();
        copy_list();
        end_test();

        start_test("list write during copy");
        set_sprite(50, `Y_ORIGIN, tile_t'(rand_byte()), 120, colour_t'(rand_byte()), 1'b1, 1'b0);
        vblank = 1'b1;
        tick();
        check_value("copy_busy before write", 1, copy_busy);
        write_list(200, byte_t'(`Y_ORIGIN - (LINE - 3)), waited);
        assert (waited > 0) else begin
            $display("list write was accepted without waiting for the copy");
            err_count++;
        end
        check_value("copy_busy after accept", 0, copy_busy);
        vblank = 1'b0;
        tick();
        copy_list();
        render_line();
        end_test();

        start_test("single sprite");
        write_list(200, 8'd0, waited);
        set_sprite(5, LINE - (rand_byte() % 16), tile_t'({rand_byte(), rand_byte()}),
                   40 + (rand_byte() % 150), colour_t'(rand_byte()), 1'b0, 1'b0);
        copy_list();
        render_line();
        end_test();

        start_test("overlap and flip");
        top_tile = tile_t'({rand_byte(), rand_byte()});
        set_sprite(10, LINE - 2, tile_t'(rand_byte()), 60, colour_t'(rand_byte()), 1'b1, 1'b0);
        set_sprite(20, LINE - 9, tile_t'(rand_byte()), 66, colour_t'(rand_byte()), 1'b0, 1'b1);
        set_sprite(30, LINE - 15, top_tile, 70, colour_t'(rand_byte()), 1'b1, 1'b1);
        // even pens of the top sprite's row go transparent
        for (int b = 0; b < 8; b++) begin
            write_gfx({1'b0, 1'(b >> 2), top_tile, 4'd0, 2'(b)}, rand_byte() & 8'hf0);
        end
        copy_list();
        render_line();
        end_test();

        start_test("clip and hidden rows");
        set_sprite(40, LINE - 7, tile_t'(rand_byte()), 250, colour_t'(rand_byte()), 1'b0, 1'b0);
        set_sprite(41, LINE + 1, tile_t'(rand_byte()), 30, colour_t'(rand_byte()), 1'b0, 1'b0);
        set_sprite(42, LINE - `SPRITE_SIZE, tile_t'(rand_byte()), 90, colour_t'(rand_byte()),
                   1'b0, 1'b0);
        copy_list();
        render_line();
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* source/sprite_engine_top.sv */
`timescale 1ns/1ns
// ====================
// standalone sprite engine, list copy plus line renderer
// video counts and vblank come from outside
// ====================

module sprite_engine_top import sprite_pkg::*; (
    input  logic       clk_sys,
    input  logic       reset,
    input  logic       vblank,
    input  line_t      h_count,
    input  line_t      v_count,
    input  logic       irq_ack,
    input  logic       list_wr_valid,
    input  list_addr_t list_wr_addr,
    input  byte_t      list_wr_data,
    input  logic       gfx_wr_valid,
    input  gfx_addr_t  gfx_wr_addr,
    input  byte_t      gfx_wr_data,
    input  byte_t      pix_x,
    output logic       irq,
    output logic       copy_busy,
    output logic       line_done,
    output logic       list_wr_ready,
    output logic       gfx_wr_ready,
    output pixel_t     pix_data
);

    // copy to renderer
    logic          buf_wr_en;
    slot_t         buf_wr_slot;
    sprite_entry_t buf_wr_entry;

    // renderer to graphics memory
    gfx_addr_t     gfx_rd_addr;
    byte_t         gfx_rd_data;
    logic          render_busy;

    sprite_list_copy u_list_copy (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .vblank        (vblank),
        .irq_ack       (irq_ack),
        .list_wr_valid (list_wr_valid),
        .list_wr_addr  (list_wr_addr),
        .list_wr_data  (list_wr_data),
        .list_wr_ready (list_wr_ready),
        .irq           (irq),
        .copy_busy     (copy_busy),
        .buf_wr_en     (buf_wr_en),
        .buf_wr_slot   (buf_wr_slot),
        .buf_wr_entry  (buf_wr_entry)
    );

    sprite_line_render u_line_render (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .h_count      (h_count),
        .v_count      (v_count),
        .buf_wr_en    (buf_wr_en),
        .buf_wr_slot  (buf_wr_slot),
        .buf_wr_entry (buf_wr_entry),
        .gfx_rd_data  (gfx_rd_data),
        .pix_x        (pix_x),
        .render_busy  (render_busy),
        .line_done    (line_done),
        .gfx_rd_addr  (gfx_rd_addr),
        .pix_data     (pix_data)
    );

    sprite_gfx_rom u_gfx_rom (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .render_busy  (render_busy),
        .gfx_wr_valid (gfx_wr_valid),
        .gfx_wr_addr  (gfx_wr_addr),
        .gfx_wr_data  (gfx_wr_data),
        .gfx_rd_addr  (gfx_rd_addr),
        .gfx_wr_ready (gfx_wr_ready),
        .gfx_rd_data  (gfx_rd_data)
    );

endmodule

/* source/sprite_line_render.sv */
`timescale 1ns/1ns
// ====================
// per-line sprite renderer with its own sprite buffer and line buffer
// starts at h_count >= 256 for line v_count + 1, idles again at h_count 0
// pix_data reads the line buffer, valid after line_done
// ====================
`include "sprite_config.svh"

module sprite_line_render import sprite_pkg::*; (
    input  logic          clk_sys,
    input  logic          reset,
    input  line_t         h_count,
    input  line_t         v_count,
    input  logic          buf_wr_en,
    input  slot_t         buf_wr_slot,
    input  sprite_entry_t buf_wr_entry,
    input  byte_t         gfx_rd_data,
    input  byte_t         pix_x,
    output logic          render_busy,
    output logic          line_done,
    output gfx_addr_t     gfx_rd_addr,
    output pixel_t        pix_data
);

    sprite_entry_t buf_mem [`SPRITE_COUNT];
    sprite_entry_t buf_rd_data;
    pixel_t        line_buf [`LINE_WIDTH];
    render_state_t state;
    slot_t         slot;
    byte_t         clear_x;
    logic [3:0]    ofs;
    line_t         cur_line;
    tile_t         spr_tile;
    xpos_t         spr_x;
    ypos_t         spr_y;
    colour_t       spr_colour;
    logic          spr_flip_x;
    logic          spr_flip_y;
    logic [3:0]    row;
    logic [3:0]    fx_ofs;
    logic [3:0]    fy_ofs;
    logic          visible;
    logic          sprite_end;
    line_t         draw_x;
    pen_t          pen;
    logic          lb_wr_en;
    line_t         lb_wr_addr;
    pixel_t        lb_wr_data;

    // ====================
    // sprite geometry
    assign row     = 4'(cur_line - line_t'(spr_y));
    assign fx_ofs  = spr_flip_x ? 4'(`SPRITE_SIZE - 1) - ofs : ofs;
    assign fy_ofs  = spr_flip_y ? 4'(`SPRITE_SIZE - 1) - row : row;
    assign visible = (cur_line >= line_t'(spr_y)) &&
                     (cur_line < line_t'(spr_y) + line_t'(`SPRITE_SIZE)) &&
                     (spr_x < line_t'(`LINE_WIDTH));
    assign draw_x  = spr_x + line_t'(ofs);

    // top address bit only used by other board variants
    assign gfx_rd_addr = {1'b0, fx_ofs[1], spr_tile, fy_ofs, fx_ofs[3:2]};
    // nibble select follows the flipped offset
    assign pen = fx_ofs[0] ? gfx_rd_data[7:4] : gfx_rd_data[3:0];

    assign sprite_end = ((state == RENDER_TEST) && !visible) ||
                        ((state == RENDER_DRAW) && (ofs == 4'(`SPRITE_SIZE - 1)));
    assign render_busy = (state != RENDER_IDLE) && (state != RENDER_WAIT);

    // line buffer write, clear or opaque pixel on screen
    always_comb begin
        lb_wr_en   = 1'b0;
        lb_wr_addr = line_t'(clear_x);
        lb_wr_data = {colour_t'(0), pen_t'(`TRANS_PEN)};
        if (state == RENDER_CLEAR) begin
            lb_wr_en = 1'b1;
        end else if ((state == RENDER_DRAW) && (pen != pen_t'(`TRANS_PEN)) &&
                     (draw_x < line_t'(`LINE_WIDTH))) begin
            lb_wr_en   = 1'b1;
            lb_wr_addr = draw_x;
            lb_wr_data = {spr_colour, pen};
        end
    end

    // ====================
    // sprite buffer, written by the list copy
    always_ff @(posedge clk_sys) begin
        if (buf_wr_en) begin
            buf_mem[buf_wr_slot] <= buf_wr_entry;
        end
        buf_rd_data <= buf_mem[slot];
    end

    // line buffer with host readout
    always_ff @(posedge clk_sys) begin
        if (lb_wr_en) begin
            line_buf[lb_wr_addr[7:0]] <= lb_wr_data;
        end
        pix_data <= line_buf[pix_x];
    end

    // ====================
    // draw fsm
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state     <= RENDER_IDLE;
            slot      <= '0;
            clear_x   <= '0;
            ofs       <= '0;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            case (state)
                RENDER_IDLE: begin
                    clear_x <= '0;
                    if (h_count >= line_t'(`LINE_WIDTH)) begin
                        state <= RENDER_CLEAR;
                    end
                end
                RENDER_CLEAR: begin
                    clear_x <= clear_x + 1'b1;
                    slot    <= '0;
                    if (clear_x == byte_t'(`LINE_WIDTH - 1)) begin
                        state <= RENDER_READ;
                    end
                end
                RENDER_READ:  state <= RENDER_LATCH;
                RENDER_LATCH: state <= RENDER_TEST;
                RENDER_TEST: begin
                    ofs <= '0;
                    if (visible) begin
                        state <= RENDER_FETCH;
                    end
                end
                RENDER_FETCH: state <= RENDER_DRAW;
                RENDER_DRAW: begin
                    ofs <= ofs + 1'b1;
                    if (!sprite_end) begin
                        state <= RENDER_FETCH;
                    end
                end
                RENDER_WAIT: if (h_count == '0) state <= RENDER_IDLE;
                default:     state <= RENDER_IDLE;
            endcase
            // later slots draw over earlier ones
            if (sprite_end) begin
                if (slot == slot_t'(`SPRITE_COUNT - 1)) begin
                    state     <= RENDER_WAIT;
                    line_done <= 1'b1;
                end else begin
                    slot  <= slot + 1'b1;
                    state <= RENDER_READ;
                end
            end
        end
    end

    // line number and current sprite fields
    always_ff @(posedge clk_sys) begin
        if (state == RENDER_IDLE) begin
            cur_line <= v_count + 1'b1;
        end
        if (state == RENDER_LATCH) begin
            {spr_tile, spr_x, spr_y, spr_colour, spr_flip_x, spr_flip_y} <= buf_rd_data;
        end
    end

    a_lb_addr_in_range: assert property (@(posedge clk_sys) disable iff (reset)
        lb_wr_en |-> (lb_wr_addr < line_t'(`LINE_WIDTH)));

endmodule

/* source/sprite_gfx_rom.sv */
`timescale 1ns/1ns
// ====================
// sprite graphics memory, 128K bytes, one clock read latency
// host loads are held off while a line renders
// ====================
`include "sprite_config.svh"

module sprite_gfx_rom import sprite_pkg::*; (
    input  logic      clk_sys,
    input  logic      reset,
    input  logic      render_busy,
    input  logic      gfx_wr_valid,
    input  gfx_addr_t gfx_wr_addr,
    input  byte_t     gfx_wr_data,
    input  gfx_addr_t gfx_rd_addr,
    output logic      gfx_wr_ready,
    output byte_t     gfx_rd_data
);

    byte_t mem [1 << `GFX_ADDR_W];
    logic  load_en;
    logic  wr_fire;

    // loads open on the first clock out of reset
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            load_en <= 1'b0;
        end else begin
            load_en <= 1'b1;
        end
    end

    assign gfx_wr_ready = load_en & ~render_busy;
    assign wr_fire      = gfx_wr_valid & gfx_wr_ready;

    // ====================
    // write port for the host, read port for the renderer
    always_ff @(posedge clk_sys) begin
        if (wr_fire) begin
            mem[gfx_wr_addr] <= gfx_wr_data;
        end
        gfx_rd_data <= mem[gfx_rd_addr];
    end

endmodule

/* source/sprite_list_copy.sv */
`timescale 1ns/1ns
// ====================
// list ram with host write port, vblank irq and list decode
// a copy takes 7 clocks per entry and cannot be restarted
// host writes stall while the copy runs
// ====================
`include "sprite_config.svh"

module sprite_list_copy import sprite_pkg::*; (
    input  logic          clk_sys,
    input  logic          reset,
    input  logic          vblank,
    input  logic          irq_ack,
    input  logic          list_wr_valid,
    input  list_addr_t    list_wr_addr,
    input  byte_t         list_wr_data,
    output logic          list_wr_ready,
    output logic          irq,
    output logic          copy_busy,
    output logic          buf_wr_en,
    output slot_t         buf_wr_slot,
    output sprite_entry_t buf_wr_entry
);

    byte_t       list_mem [`SPRITE_COUNT * `SPRITE_BYTES];
    list_addr_t  rd_addr;
    byte_t       rd_data;
    logic        vblank_q;
    logic        vbl_rise;
    logic        vbl_fall;
    copy_state_t state;
    copy_state_t state_next;
    slot_t       slot;
    tile_t       tile;
    xpos_t       xpos;
    ypos_t       ypos;
    colour_t     colour;
    logic        x_msb;
    logic        flip_x;
    logic        flip_y;

    assign vbl_rise = vblank & ~vblank_q;
    assign vbl_fall = ~vblank & vblank_q;

    // ====================
    // list ram, registered read
    always_ff @(posedge clk_sys) begin
        if (list_wr_valid && list_wr_ready) begin
            list_mem[list_wr_addr] <= list_wr_data;
        end
        rd_data <= list_mem[rd_addr];
    end

    // vblank edges and cpu interrupt
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            vblank_q <= 1'b0;
            irq      <= 1'b0;
        end else begin
            vblank_q <= vblank;
            if (vbl_rise) begin
                irq <= 1'b1;
            end else if (irq_ack || vbl_fall) begin
                irq <= 1'b0;
            end
        end
    end

    // ====================
    // copy fsm
    always_comb begin
        state_next = state;
        case (state)
            COPY_IDLE:  if (vbl_rise) state_next = COPY_ADDR;
            COPY_ADDR:  state_next = COPY_Y;
            COPY_Y:     state_next = COPY_TILE;
            COPY_TILE:  state_next = COPY_ATTR;
            COPY_ATTR:  state_next = COPY_X;
            COPY_X:     state_next = COPY_WRITE;
            COPY_WRITE: state_next = COPY_NEXT;
            COPY_NEXT: begin
                if (slot == slot_t'(`SPRITE_COUNT - 1)) begin
                    state_next = COPY_IDLE;
                end else begin
                    state_next = COPY_ADDR;
                end
            end
            default:    state_next = COPY_IDLE;
        endcase
    end

    // read address runs one byte ahead of the decode
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state         <= COPY_IDLE;
            slot          <= '0;
            rd_addr       <= '0;
            list_wr_ready <= 1'b0;
        end else begin
            state         <= state_next;
            list_wr_ready <= (state_next == COPY_IDLE);
            case (state)
                COPY_IDLE: begin
                    slot    <= '0;
                    rd_addr <= '0;
                end
                COPY_ADDR, COPY_Y, COPY_TILE: rd_addr <= rd_addr + 1'b1;
                COPY_NEXT: begin
                    slot    <= slot + 1'b1;
                    rd_addr <= rd_addr + 1'b1;
                end
                default: ;
            endcase
        end
    end

    // byte decode into the entry fields
    always_ff @(posedge clk_sys) begin
        case (state)
            COPY_Y:    ypos <= ypos_t'(`Y_ORIGIN) - rd_data;
            COPY_TILE: tile[7:0] <= rd_data;
            COPY_ATTR: begin
                x_msb   <= rd_data[0];
                tile[8] <= rd_data[1];
                flip_x  <= rd_data[2];
                flip_y  <= rd_data[3];
                colour  <= rd_data[7:4];
            end
            COPY_X:    xpos <= {x_msb, rd_data} - xpos_t'(`X_BIAS);
            default: ;
        endcase
    end

    assign copy_busy    = (state != COPY_IDLE);
    assign buf_wr_en    = (state == COPY_WRITE);
    assign buf_wr_slot  = slot;
    assign buf_wr_entry = {tile, xpos, ypos, colour, flip_x, flip_y};

    // ready register must track the fsm exactly
    a_ready_not_busy: assert property (@(posedge clk_sys) disable iff (reset)
        copy_busy |-> !list_wr_ready);

endmodule

/* source/sprite_pkg.sv */
// ====================
// shared types for the sprite engine
// entry packs tile, x, y, colour, flip x, flip y from the msb down
// ====================
`include "sprite_config.svh"

package sprite_pkg;

    typedef logic [7:0]               list_addr_t;
    typedef logic [7:0]               byte_t;
    typedef logic [5:0]               slot_t;
    typedef logic [8:0]               tile_t;
    typedef logic [8:0]               xpos_t;
    typedef logic [7:0]               ypos_t;
    typedef logic [3:0]               colour_t;
    typedef logic [3:0]               pen_t;
    // colour in the upper nibble, pen in the lower
    typedef logic [7:0]               pixel_t;
    typedef logic [31:0]              sprite_entry_t;
    typedef logic [`GFX_ADDR_W-1:0]   gfx_addr_t;
    // also wide enough for the horizontal count
    typedef logic [8:0]               line_t;

    // seven states per entry while copying
    typedef enum logic [2:0] {
        COPY_IDLE, COPY_ADDR, COPY_Y, COPY_TILE,
        COPY_ATTR, COPY_X, COPY_WRITE, COPY_NEXT
    } copy_state_t;

    typedef enum logic [2:0] {
        RENDER_IDLE, RENDER_CLEAR, RENDER_READ, RENDER_LATCH,
        RENDER_TEST, RENDER_FETCH, RENDER_DRAW, RENDER_WAIT
    } render_state_t;

endpackage

/* include/sprite_config.svh */
// ====================
// build constants for the sprite engine
// first board variant only, so the transparent pen is fixed
// gfx rom width must cover a 9-bit tile with 16x16 4bpp pixels
// ====================
`ifndef SPRITE_CONFIG_SVH
`define SPRITE_CONFIG_SVH

// ==================== sprite list
// entries in the host list and bytes per entry
`define SPRITE_COUNT 64
`define SPRITE_BYTES 4

// square sprites, one line buffer per display line
`define SPRITE_SIZE  16
`define LINE_WIDTH   256

// ==================== decode constants
// list y byte counts up from the bottom of the screen
`define Y_ORIGIN     240
// 9-bit x is biased so that off-screen left is reachable
`define X_BIAS       128

// pen value that never reaches the line buffer
`define TRANS_PEN    0

// ==================== graphics memory
// 128K bytes of sprite graphics
`define GFX_ADDR_W   17

`endif
